//--- src/trs_io_cfg.svh
`ifndef TRS_IO_CFG_SVH
`define TRS_IO_CFG_SVH

// z80 i/o port map
`define TRS_IO_PORT      8'h1F
`define FREHD_PORT_HI    4'hC
`define PRINTER_PORT_HI  6'h3E
`define FLASH_CTRL_PORT  8'hFC
`define FLASH_DATA_PORT  8'hFD

// identification bytes returned to the ESP
`define ESP_COOKIE       8'hAF
`define VERSION_MAJOR    3'd0
`define VERSION_MINOR    5'd3

// esp request pulse length in clk cycles
`define ESP_REQ_CYCLES   50
`define ESP_REQ_CNT_W    6

// flash sck period, one bit per period
`define FLASH_BIT_CYCLES 16
`define FLASH_CNT_W      8

`define MAX_PARAMS       3

`endif

//--- src/esp_cmd_pkg.sv
package esp_cmd_pkg;

  // opcodes sent by the ESP as the first byte of a command
  typedef enum logic [7:0] {
    get_cookie       = 8'd0,
    dbus_write       = 8'd4,
    data_ready       = 8'd5,
    get_version      = 8'd15,
    set_led          = 8'd26,
    get_config       = 8'd27,
    set_spi_ctrl_reg = 8'd29,
    set_spi_data     = 8'd30,
    get_spi_data     = 8'd31,
    set_esp_status   = 8'd32
  } esp_cmd_e;

  typedef enum logic [1:0] {
    idle       = 2'd0,
    read_bytes = 2'd1
  } parser_state_e;

endpackage

//--- src/trs_bus_pkg.sv
package trs_bus_pkg;

  // status code shown to the ESP on esp_s
  typedef enum logic [3:0] {
    trs_io_in  = 4'd0,
    trs_io_out = 4'd1,
    frehd_in   = 4'd2,
    frehd_out  = 4'd3,
    printer_rd = 4'd4,
    printer_wr = 4'd5,
    code_idle  = 4'hF
  } esp_code_e;

  typedef struct packed {
    logic       cs;
    logic       wpn;
    logic [5:0] rsvd;
  } flash_ctrl_s;

  typedef union packed {
    logic [7:0]  raw;
    flash_ctrl_s f;
  } flash_ctrl_u;

endpackage

//--- src/esp_spi_slave.sv
`timescale 1ns/1ps

module esp_spi_slave (
  input  logic       clk,
  input  logic       cass_out_sel_n,
  input  logic       esp_cs_n,
  input  logic       sck,
  input  logic       mosi,
  input  logic [7:0] tx_byte,
  output logic       miso,
  output logic [7:0] rx_byte,
  output logic       rx_valid
);

  logic [2:0] sck_q;
  logic [1:0] cs_q;
  logic [1:0] mosi_q;
  logic [2:0] bit_cnt;
  logic [7:0] tx_q;
  logic       cs_active;
  logic       sck_rise;
  logic       sck_fall;

  assign cs_active = ~cs_q[1];
  assign sck_rise  = (sck_q[2:1] == 2'b01);
  assign sck_fall  = (sck_q[2:1] == 2'b10);

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_q    <= '0;
      cs_q     <= 2'b11;
      mosi_q   <= '0;
      bit_cnt  <= '0;
      tx_q     <= '0;
      rx_valid <= 1'b0;
    end else begin
      sck_q    <= {sck_q[1:0], sck};
      cs_q     <= {cs_q[0], esp_cs_n};
      mosi_q   <= {mosi_q[0], mosi};
      rx_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= '0;
      end else begin
        if (sck_rise) begin
          bit_cnt <= bit_cnt + 3'd1;
          rx_valid <= (bit_cnt == 3'd7);
        end
        // response byte is loaded on the first falling edge of a byte
        if (sck_fall) begin
          if (bit_cnt == 3'd1) begin
            tx_q <= tx_byte;
          end else begin
            tx_q <= {tx_q[6:0], 1'b0};
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) begin
      rx_byte <= {rx_byte[6:0], mosi_q[1]};
    end
  end

  assign miso = cs_active ? tx_q[7] : 1'bz;

  a_no_rx_without_cs : assert property (
    @(posedge clk) disable iff (!cass_out_sel_n) rx_valid |-> cs_active
  );

endmodule

//--- src/esp_cmd_parser.sv
`timescale 1ns/1ps
`include "trs_io_cfg.svh"

module esp_cmd_parser import esp_cmd_pkg::*; (
  input  logic       clk,
  input  logic       cass_out_sel_n,
  input  logic [7:0] rx_byte,
  input  logic       rx_valid,
  output esp_cmd_e   cmd,
  output logic [7:0] param0,
  output logic [7:0] param1,
  output logic [7:0] param2,
  output logic       exec,
  output logic       cmd_error
);

  parser_state_e state;
  logic [1:0]    cnt;
  logic [1:0]    idx;
  logic [7:0]    params [0:`MAX_PARAMS-1];

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state     <= idle;
      cnt       <= '0;
      idx       <= '0;
      exec      <= 1'b0;
      cmd_error <= 1'b0;
    end else begin
      exec <= 1'b0;
      if (rx_valid) begin
        case (state)
          idle: begin
            idx <= '0;
            case (rx_byte)
              get_cookie, get_version, get_config, get_spi_data, data_ready: begin
                exec <= 1'b1;
              end
              dbus_write, set_led, set_spi_ctrl_reg, set_spi_data, set_esp_status: begin
                cnt   <= 2'd1;
                state <= read_bytes;
              end
              // sticky until reset
              default: cmd_error <= 1'b1;
            endcase
          end
          read_bytes: begin
            idx <= idx + 2'd1;
            if (cnt == 2'd1) begin
              exec  <= 1'b1;
              state <= idle;
            end else begin
              cnt <= cnt - 2'd1;
            end
          end
          default: state <= idle;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid && state == idle) begin
      cmd <= esp_cmd_e'(rx_byte);
    end
    if (rx_valid && state == read_bytes) begin
      params[idx] <= rx_byte;
    end
  end

  assign param0 = params[0];
  assign param1 = params[1];
  assign param2 = params[2];

  a_idx_range : assert property (
    @(posedge clk) disable iff (!cass_out_sel_n)
      (rx_valid && state == read_bytes) |-> (idx < `MAX_PARAMS)
  );

endmodule

//--- src/esp_cmd_regs.sv
`timescale 1ns/1ps
`include "trs_io_cfg.svh"

module esp_cmd_regs import esp_cmd_pkg::*; (
  input  logic       clk,
  input  logic       cass_out_sel_n,
  input  esp_cmd_e   cmd,
  input  logic [7:0] param0,
  input  logic       exec,
  input  logic [3:0] conf,
  input  logic [7:0] spi_rdata,
  output logic [7:0] tx_byte,
  output logic       led_red,
  output logic       led_green,
  output logic       led_blue,
  output logic [7:0] esp_status,
  output logic [7:0] z80_rdata,
  output logic       data_ready_set
);

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      led_red        <= 1'b0;
      led_green      <= 1'b0;
      led_blue       <= 1'b0;
      esp_status     <= '0;
      data_ready_set <= 1'b0;
    end else begin
      data_ready_set <= exec && (cmd == data_ready);
      if (exec && cmd == set_led) begin
        led_red   <= param0[0];
        led_green <= param0[1];
        led_blue  <= param0[2];
      end
      if (exec && cmd == set_esp_status) begin
        esp_status <= param0;
      end
    end
  end

  // response goes out in the byte after the command
  always_ff @(posedge clk) begin
    if (exec) begin
      case (cmd)
        get_cookie:   tx_byte <= `ESP_COOKIE;
        get_version:  tx_byte <= {`VERSION_MAJOR, `VERSION_MINOR};
        get_config:   tx_byte <= {4'b0000, ~conf};
        get_spi_data: tx_byte <= spi_rdata;
        dbus_write:   z80_rdata <= param0;
        default: ;
      endcase
    end
  end

endmodule

//--- src/z80_io_decode.sv
`timescale 1ns/1ps
`include "trs_io_cfg.svh"

module z80_io_decode import trs_bus_pkg::*; (
  input  logic       clk,
  input  logic       cass_out_sel_n,
  input  logic [7:0] io_addr,
  input  logic       io_in_n,
  input  logic       io_out_n,
  input  logic       use_internal,
  input  logic       esp_done,
  input  logic [7:0] z80_rdata,
  input  logic [7:0] spi_rdata,
  input  logic       data_ready_set,
  output esp_code_e  esp_s,
  output logic       esp_req,
  output logic       io_wait,
  output logic       io_int,
  output logic [7:0] io_rdata,
  output logic       z80_ctrl_we,
  output logic       z80_data_we
);

  logic [1:0]              in_q;
  logic [1:0]              out_q;
  logic [2:0]              done_q;
  logic                    io_idle_d;
  logic [`ESP_REQ_CNT_W-1:0] req_cnt;
  logic                    rd;
  logic                    wr;
  logic                    start;
  logic                    trs_io_hit;
  logic                    frehd_hit;
  logic                    printer_hit;
  logic                    esp_sel;
  esp_code_e               code;

  assign rd    = ~in_q[1];
  assign wr    = ~out_q[1];
  // falling edge of the and of both strobes, once per cycle
  assign start = io_idle_d & (rd | wr);

  assign trs_io_hit  = (io_addr == `TRS_IO_PORT);
  assign frehd_hit   = (io_addr[7:4] == `FREHD_PORT_HI);
  assign printer_hit = (io_addr[7:2] == `PRINTER_PORT_HI);
  assign esp_sel     = use_internal & (trs_io_hit | frehd_hit | printer_hit) & (rd | wr);

  assign z80_ctrl_we = start & wr & (io_addr == `FLASH_CTRL_PORT);
  assign z80_data_we = start & wr & (io_addr == `FLASH_DATA_PORT);
  assign esp_req     = (req_cnt != '0);

  always_comb begin
    code = code_idle;
    if (trs_io_hit) begin
      code = rd ? trs_io_in : trs_io_out;
    end else if (frehd_hit) begin
      code = rd ? frehd_in : frehd_out;
    end else if (printer_hit) begin
      code = rd ? printer_rd : printer_wr;
    end
  end

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      in_q      <= 2'b11;
      out_q     <= 2'b11;
      done_q    <= '0;
      io_idle_d <= 1'b1;
      req_cnt   <= '0;
      io_wait   <= 1'b0;
      io_int    <= 1'b0;
      esp_s     <= code_idle;
    end else begin
      in_q      <= {in_q[0], io_in_n};
      out_q     <= {out_q[0], io_out_n};
      done_q    <= {done_q[1:0], esp_done};
      io_idle_d <= in_q[1] & out_q[1];
      if (start && esp_sel) begin
        req_cnt <= `ESP_REQ_CNT_W'(`ESP_REQ_CYCLES);
        io_wait <= 1'b1;
        esp_s   <= code;
      end else begin
        if (req_cnt != '0) begin
          req_cnt <= req_cnt - 1'b1;
        end
        // esp done, release the z80
        if (done_q[2:1] == 2'b01) begin
          io_wait <= 1'b0;
        end
        if (!esp_sel) begin
          esp_s <= code_idle;
        end
      end
      if (data_ready_set) begin
        io_int <= 1'b1;
      end else if (start && trs_io_hit) begin
        io_int <= 1'b0;
      end
    end
  end

  always_comb begin
    if (trs_io_hit || frehd_hit || printer_hit) begin
      io_rdata = z80_rdata;
    end else if (io_addr == `FLASH_DATA_PORT) begin
      io_rdata = spi_rdata;
    end else begin
      io_rdata = 8'hFF;
    end
  end

  a_req_in_wait : assert property (
    @(posedge clk) disable iff (!cass_out_sel_n) esp_req |-> io_wait
  );

endmodule

//--- src/flash_bus_arbiter.sv
`timescale 1ns/1ps

module flash_bus_arbiter import esp_cmd_pkg::*; (
  input  logic       clk,
  input  logic       cass_out_sel_n,
  input  logic       z80_ctrl_we,
  input  logic       z80_data_we,
  input  logic [7:0] io_wdata,
  input  logic       exec,
  input  esp_cmd_e   cmd,
  input  logic [7:0] param0,
  output logic       ctrl_we,
  output logic       data_we,
  output logic [7:0] wdata
);

  logic esp_ctrl_req;
  logic esp_data_req;
  logic z80_req;
  logic pend_v;
  logic pend_ctrl;

  assign esp_ctrl_req = exec && (cmd == set_spi_ctrl_reg);
  assign esp_data_req = exec && (cmd == set_spi_data);
  assign z80_req      = z80_ctrl_we | z80_data_we;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      ctrl_we   <= 1'b0;
      data_we   <= 1'b0;
      pend_v    <= 1'b0;
      pend_ctrl <= 1'b0;
    end else begin
      // z80 first, esp waits a cycle on collision
      pend_v <= z80_req & (esp_ctrl_req | esp_data_req);
      if (esp_ctrl_req || esp_data_req) begin
        pend_ctrl <= esp_ctrl_req;
      end
      if (z80_req) begin
        ctrl_we <= z80_ctrl_we;
        data_we <= z80_data_we;
      end else if (pend_v) begin
        ctrl_we <= pend_ctrl;
        data_we <= ~pend_ctrl;
      end else begin
        ctrl_we <= esp_ctrl_req;
        data_we <= esp_data_req;
      end
    end
  end

  // param0 holds until the next command byte
  always_ff @(posedge clk) begin
    wdata <= z80_req ? io_wdata : param0;
  end

  a_one_grant : assert property (
    @(posedge clk) disable iff (!cass_out_sel_n) !(ctrl_we && data_we)
  );

endmodule

//--- src/flash_spi_master.sv
`timescale 1ns/1ps
`include "trs_io_cfg.svh"

module flash_spi_master import trs_bus_pkg::*; (
  input  logic       clk,
  input  logic       cass_out_sel_n,
  input  logic       ctrl_we,
  input  logic       data_we,
  input  logic [7:0] wdata,
  input  logic       flash_so,
  output logic       flash_cs_n,
  output logic       flash_sck,
  output logic       flash_si,
  output logic [7:0] spi_rdata,
  output logic       busy
);

  localparam int HALF_BIT = $clog2(`FLASH_BIT_CYCLES) - 1;

  flash_ctrl_u            ctrl_q;
  logic [`FLASH_CNT_W-1:0] cnt;
  logic [7:0]             shift_q;
  logic                   bit_tick;

  // msb of the counter doubles as the busy flag
  assign busy     = cnt[`FLASH_CNT_W-1];
  assign bit_tick = (cnt[HALF_BIT-1:0] == '0);

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      ctrl_q   <= '0;
      cnt      <= '0;
      flash_si <= 1'b0;
    end else begin
      if (ctrl_we) begin
        ctrl_q.raw <= wdata;
      end
      if (busy) begin
        cnt <= cnt + 1'b1;
        // start of the low half
        if (bit_tick && !cnt[HALF_BIT]) begin
          flash_si <= shift_q[7];
        end
      end else if (data_we) begin
        cnt <= {1'b1, {(`FLASH_CNT_W-1){1'b0}}};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (busy) begin
      if (bit_tick && cnt[HALF_BIT]) begin
        shift_q <= {shift_q[6:0], flash_so};
      end
    end else if (data_we) begin
      shift_q <= wdata;
    end
  end

  // wpn has no pin on this board
  assign flash_cs_n = ~ctrl_q.f.cs;
  assign flash_sck  = cnt[HALF_BIT];
  assign spi_rdata  = shift_q;

endmodule

//--- src/trs_io_top.sv
`timescale 1ns/1ps

module trs_io_top import esp_cmd_pkg::*, trs_bus_pkg::*; (
  input  logic       clk,
  input  logic       cass_out_sel_n,
  input  logic       esp_cs_n,
  input  logic       sck,
  input  logic       mosi,
  output logic       miso,
  output esp_code_e  esp_s,
  output logic       esp_req,
  input  logic       esp_done,
  input  logic [7:0] io_addr,
  input  logic [7:0] io_wdata,
  output logic [7:0] io_rdata,
  input  logic       io_in_n,
  input  logic       io_out_n,
  output logic       io_wait,
  output logic       io_int,
  input  logic [3:0] conf,
  output logic       led_red,
  output logic       led_green,
  output logic       led_blue,
  output logic       led_err,
  output logic       flash_cs_n,
  output logic       flash_sck,
  output logic       flash_si,
  input  logic       flash_so
);

  logic [7:0] rx_byte;
  logic       rx_valid;
  logic [7:0] tx_byte;
  esp_cmd_e   cmd;
  logic [7:0] param0;
  logic       exec;
  logic [7:0] z80_rdata;
  logic [7:0] spi_rdata;
  logic       data_ready_set;
  logic       z80_ctrl_we;
  logic       z80_data_we;
  logic       ctrl_we;
  logic       data_we;
  logic [7:0] wdata;

  esp_spi_slave esp_spi_slave_inst (
    .clk(clk), .cass_out_sel_n(cass_out_sel_n), .esp_cs_n(esp_cs_n), .sck(sck),
    .mosi(mosi), .tx_byte(tx_byte), .miso(miso), .rx_byte(rx_byte), .rx_valid(rx_valid)
  );

  esp_cmd_parser esp_cmd_parser_inst (
    .clk(clk), .cass_out_sel_n(cass_out_sel_n), .rx_byte(rx_byte), .rx_valid(rx_valid),
    .cmd(cmd), .param0(param0), .param1(), .param2(), .exec(exec), .cmd_error(led_err)
  );

  esp_cmd_regs esp_cmd_regs_inst (
    .clk(clk), .cass_out_sel_n(cass_out_sel_n), .cmd(cmd), .param0(param0), .exec(exec),
    .conf(conf), .spi_rdata(spi_rdata), .tx_byte(tx_byte), .led_red(led_red),
    .led_green(led_green), .led_blue(led_blue), .esp_status(), .z80_rdata(z80_rdata),
    .data_ready_set(data_ready_set)
  );

  z80_io_decode z80_io_decode_inst (
    .clk(clk), .cass_out_sel_n(cass_out_sel_n), .io_addr(io_addr), .io_in_n(io_in_n),
    .io_out_n(io_out_n), .use_internal(conf[3]), .esp_done(esp_done),
    .z80_rdata(z80_rdata), .spi_rdata(spi_rdata), .data_ready_set(data_ready_set),
    .esp_s(esp_s), .esp_req(esp_req), .io_wait(io_wait), .io_int(io_int),
    .io_rdata(io_rdata), .z80_ctrl_we(z80_ctrl_we), .z80_data_we(z80_data_we)
  );

  flash_bus_arbiter flash_bus_arbiter_inst (
    .clk(clk), .cass_out_sel_n(cass_out_sel_n), .z80_ctrl_we(z80_ctrl_we),
    .z80_data_we(z80_data_we), .io_wdata(io_wdata), .exec(exec), .cmd(cmd),
    .param0(param0), .ctrl_we(ctrl_we), .data_we(data_we), .wdata(wdata)
  );

  flash_spi_master flash_spi_master_inst (
    .clk(clk), .cass_out_sel_n(cass_out_sel_n), .ctrl_we(ctrl_we), .data_we(data_we),
    .wdata(wdata), .flash_so(flash_so), .flash_cs_n(flash_cs_n), .flash_sck(flash_sck),
    .flash_si(flash_si), .spi_rdata(spi_rdata), .busy()
  );

endmodule

//--- sim/tb_trs_io.sv
`timescale 1ns/1ps
`include "trs_io_cfg.svh"

module tb_trs_io import esp_cmd_pkg::*, trs_bus_pkg::*; ();

  localparam int DRV  = 10;
  localparam int HALF = 8;
  localparam int SPI_BYTE_CYCLES = HALF + 16 * HALF + 12;
  localparam int SPI_BYTES       = 16;
  localparam int Z80_CYCLES      = 8 * 10 + `ESP_REQ_CYCLES + 20;
  localparam int FLASH_CYCLES    = 2 * (10 * `FLASH_BIT_CYCLES);
  // twice the summed length of all tests
  localparam int CYCLE_LIMIT = 2 * (SPI_BYTES * SPI_BYTE_CYCLES + Z80_CYCLES + FLASH_CYCLES);

  logic       clk;
  logic       cass_out_sel_n;
  logic       esp_cs_n;
  logic       sck;
  logic       mosi;
  logic       miso;
  esp_code_e  esp_s;
  logic       esp_req;
  logic       esp_done;
  logic [7:0] io_addr;
  logic [7:0] io_wdata;
  logic [7:0] io_rdata;
  logic       io_in_n;
  logic       io_out_n;
  logic       io_wait;
  logic       io_int;
  logic [3:0] conf;
  logic       led_red;
  logic       led_green;
  logic       led_blue;
  logic       led_err;
  logic       flash_cs_n;
  logic       flash_sck;
  logic       flash_si;
  logic       flash_so;

  int         val_errs = 0;
  int         prop_errs = 0;
  int         other_errs = 0;
  int         cycles = 0;
  int         n;
  logic [15:0] lfsr_q;
  logic [7:0] r;
  logic [7:0] x;
  logic [7:0] y;
  logic [7:0] z;

  trs_io_top trs_io_top_inst (.*);

  always #50 clk = ~clk;

  // flash answers each bit with its complement
  always @(posedge flash_sck) begin
    flash_so <= ~flash_si;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout, the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("test failed");
      $finish;
    end
  end

  a_err_sticky : assert property (
    @(posedge clk) disable iff (!cass_out_sel_n) led_err |=> led_err
  ) else begin
    prop_errs++;
    $display("ERR %0t: led_err cleared after it was set", $time);
  end

  a_wait_release : assert property (
    @(posedge clk) disable iff (!cass_out_sel_n) $fell(io_wait) |-> $past(esp_done, 2)
  ) else begin
    prop_errs++;
    $display("ERR %0t: io_wait fell without esp_done", $time);
  end

  a_sck_needs_cs : assert property (
    @(posedge clk) disable iff (!cass_out_sel_n) $rose(flash_sck) |-> !flash_cs_n
  ) else begin
    prop_errs++;
    $display("ERR %0t: flash_sck pulse with flash_cs_n high", $time);
  end

  a_req_has_code : assert property (
    @(posedge clk) disable iff (!cass_out_sel_n) $rose(esp_req) |-> esp_s != code_idle
  ) else begin
    prop_errs++;
    $display("ERR %0t: esp_req raised with idle esp_s", $time);
  end

  task automatic step();
    @(posedge clk);
    #DRV;
  endtask

  task automatic wait_cycles(input int cnt);
    repeat (cnt) step();
  endtask

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic next_rand_byte(output logic [7:0] b);
    b = '0;
    repeat (8) begin
      lfsr_q = lfsr_step(lfsr_q);
      b = {b[6:0], lfsr_q[0]};
    end
  endtask

  task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
    assert (got === exp) else begin
      val_errs++;
      $display("ERR %0t: %s is %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  // one byte, msb first, miso read late in each low half
  task automatic exchange_byte(input logic [7:0] tx, output logic [7:0] rx);
    int i;
    rx = '0;
    mosi = tx[7];
    wait_cycles(HALF);
    for (i = 0; i < 8; i++) begin
      sck = 1'b1;
      wait_cycles(HALF);
      sck = 1'b0;
      if (i < 7) begin
        mosi = tx[6 - i];
      end
      wait_cycles(HALF);
      rx = {rx[6:0], miso};
    end
  endtask

  task automatic send_two_bytes(input logic [7:0] b0, input logic [7:0] b1,
                                output logic [7:0] resp);
    logic [7:0] first;
    esp_cs_n = 1'b0;
    wait_cycles(4);
    exchange_byte(b0, first);
    exchange_byte(b1, resp);
    wait_cycles(4);
    esp_cs_n = 1'b1;
    wait_cycles(4);
  endtask

  task automatic send_one_byte(input logic [7:0] b0);
    logic [7:0] unused;
    esp_cs_n = 1'b0;
    wait_cycles(4);
    exchange_byte(b0, unused);
    wait_cycles(4);
    esp_cs_n = 1'b1;
    wait_cycles(4);
  endtask

  task automatic z80_out(input logic [7:0] addr, input logic [7:0] data);
    io_addr = addr;
    io_wdata = data;
    io_out_n = 1'b0;
    wait_cycles(4);
    io_out_n = 1'b1;
    wait_cycles(3);
  endtask

  task automatic z80_in(input logic [7:0] addr, output logic [7:0] data);
    io_addr = addr;
    io_in_n = 1'b0;
    wait_cycles(4);
    data = io_rdata;
    io_in_n = 1'b1;
    wait_cycles(3);
  endtask

  // checks si on every sck rise, then a quiet bus
  task automatic watch_flash(input logic [7:0] exp);
    int   cnt;
    int   rises;
    logic prev;
    cnt = 0;
    rises = 0;
    prev = flash_sck;
    while (rises < 8 && cnt < 1000) begin
      step();
      cnt++;
      if (flash_sck && !prev) begin
        check_byte("flash si bit", {7'b0, flash_si}, {7'b0, exp[7 - rises]});
        rises++;
      end
      prev = flash_sck;
    end
    if (rises < 8) begin
      other_errs++;
      $display("flash transfer gave only %0d clock pulses", rises);
    end
    repeat (2 * `FLASH_BIT_CYCLES) begin
      step();
      if (flash_sck && !prev) begin
        val_errs++;
        $display("ERR %0t: extra flash clock pulse after the byte", $time);
      end
      prev = flash_sck;
    end
  endtask

  initial begin
    clk = 1'b0;
    cass_out_sel_n = 1'b0;
    esp_cs_n = 1'b1;
    sck = 1'b0;
    mosi = 1'b0;
    esp_done = 1'b0;
    io_addr = 8'h00;
    io_wdata = 8'h00;
    io_in_n = 1'b1;
    io_out_n = 1'b1;
    conf = 4'b1010;
    flash_so = 1'b0;
    lfsr_q = 16'd48;
    wait_cycles(3);
    cass_out_sel_n = 1'b1;
    wait_cycles(2);
    check_byte("outputs after reset",
               {esp_req, io_wait, io_int, flash_cs_n, flash_sck,
                led_red | led_green | led_blue, led_err, 1'b0}, 8'b0001_0000);
    check_byte("esp_s after reset", {4'h0, esp_s}, {4'h0, code_idle});

    // identification and error flag
    send_two_bytes(get_cookie, 8'h00, r);
    check_byte("cookie", r, 8'hAF);
    send_two_bytes(get_version, 8'h00, r);
    check_byte("version", r, 8'h03);
    // conf is 1010 here, so the low nibble reads back as 0101
    send_two_bytes(get_config, 8'h00, r);
    check_byte("config", r, 8'h05);
    check_byte("led_err before bad opcode", {7'b0, led_err}, 8'h00);
    send_one_byte(8'h07);
    check_byte("led_err after bad opcode", {7'b0, led_err}, 8'h01);

    next_rand_byte(x);
    send_two_bytes(set_led, x, r);
    check_byte("leds", {5'b0, led_blue, led_green, led_red}, {5'b0, x[2:0]});

    // esp service of an OUT to 1Fh
    io_addr = `TRS_IO_PORT;
    next_rand_byte(io_wdata);
    io_out_n = 1'b0;
    n = 0;
    while (!esp_req && n < 10) begin
      step();
      n++;
    end
    if (!esp_req) begin
      other_errs++;
      $display("no ESP request seen for the OUT to port 1Fh");
    end
    check_byte("esp_s on OUT to 1Fh", {4'h0, esp_s}, {4'h0, trs_io_out});
    n = 0;
    while (esp_req && n < 200) begin
      step();
      n++;
    end
    assert (n == `ESP_REQ_CYCLES) else begin
      val_errs++;
      $display("ERR %0t: esp_req high %0d cycles, expected %0d", $time, n, `ESP_REQ_CYCLES);
    end
    check_byte("io_wait before esp_done", {7'b0, io_wait}, 8'h01);
    esp_done = 1'b1;
    n = 0;
    while (io_wait && n < 10) begin
      step();
      n++;
    end
    assert (n >= 2 && n <= 3) else begin
      val_errs++;
      $display("ERR %0t: io_wait fell %0d cycles after esp_done", $time, n);
    end
    io_out_n = 1'b1;
    esp_done = 1'b0;
    wait_cycles(3);
    check_byte("esp_s after the cycle", {4'h0, esp_s}, {4'h0, code_idle});

    // same OUT with the esp ports disabled
    conf = 4'b0010;
    io_out_n = 1'b0;
    n = 0;
    repeat (10) begin
      step();
      if (esp_req || io_wait) begin
        n++;
      end
    end
    io_out_n = 1'b1;
    wait_cycles(3);
    check_byte("request cycles with conf bit 3 low", n[7:0], 8'h00);

    next_rand_byte(x);
    send_two_bytes(dbus_write, x, r);
    z80_in(8'hC5, r);
    check_byte("frehd IN data", r, x);
    send_one_byte(data_ready);
    check_byte("io_int after data_ready", {7'b0, io_int}, 8'h01);
    z80_out(`TRS_IO_PORT, 8'h00);
    check_byte("io_int after access to 1Fh", {7'b0, io_int}, 8'h00);

    // flash from the z80 side
    z80_out(`FLASH_CTRL_PORT, 8'h80);
    check_byte("flash_cs_n", {7'b0, flash_cs_n}, 8'h00);
    next_rand_byte(y);
    fork
      z80_out(`FLASH_DATA_PORT, y);
      watch_flash(y);
    join
    z80_in(`FLASH_DATA_PORT, r);
    check_byte("flash read back on FDh", r, ~y);

    // flash from the esp side, through the arbiter
    next_rand_byte(z);
    fork
      send_two_bytes(set_spi_data, z, r);
      watch_flash(z);
    join
    send_two_bytes(get_spi_data, 8'h00, r);
    check_byte("flash read back over ESP", r, ~z);
    check_byte("led_err at end", {7'b0, led_err}, 8'h01);

    $display("value errors %0d, assertion errors %0d, other failures %0d",
             val_errs, prop_errs, other_errs);
    if (val_errs + prop_errs + other_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+src
src/esp_cmd_pkg.sv
src/trs_bus_pkg.sv
src/esp_spi_slave.sv
src/esp_cmd_parser.sv
src/esp_cmd_regs.sv
src/z80_io_decode.sv
src/flash_bus_arbiter.sv
src/flash_spi_master.sv
src/trs_io_top.sv
sim/tb_trs_io.sv

//--- Bender.yml
package:
  name: trs_io

sources:
  - include_dirs:
      - src
    files:
      - src/esp_cmd_pkg.sv
      - src/trs_bus_pkg.sv
      - src/esp_spi_slave.sv
      - src/esp_cmd_parser.sv
      - src/esp_cmd_regs.sv
      - src/z80_io_decode.sv
      - src/flash_bus_arbiter.sv
      - src/flash_spi_master.sv
      - src/trs_io_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/tb_trs_io.sv
